// ==== hdl/ctrlPkg.sv ====
package ctrlPkg;

  //////////////////////////////
  // Field and width types
  //////////////////////////////
  typedef logic [31:0] instrT;       // Raw instruction word
  typedef logic [4:0]  regAdrT;      // Register file address
  typedef logic [6:0]  opcodeT;      // Major opcode, instr[6:0]
  typedef logic [2:0]  funct3T;      // Funct3 field, also the ALU select
  typedef logic [6:0]  funct7T;      // Funct7 field, instr[31:25]
  typedef logic [2:0]  immSrcT;      // Immediate format select
  typedef logic [2:0]  resultSrcT;   // Writeback source select
  typedef logic [1:0]  memRwT;       // Bit 1 read, bit 0 write
  typedef logic [1:0]  fwdSelT;      // Forwarding mux select
  typedef logic [1:0]  flagsT;       // {eq, lt} from the comparator

  //////////////////////////////
  // Opcodes
  //////////////////////////////
  localparam opcodeT opLoad    = 7'b0000011;  // lb/lh/lw/lbu/lhu
  localparam opcodeT opMiscMem = 7'b0001111;  // fence
  localparam opcodeT opOpImm   = 7'b0010011;  // I-type ALU
  localparam opcodeT opAuipc   = 7'b0010111;
  localparam opcodeT opStore   = 7'b0100011;  // sb/sh/sw
  localparam opcodeT opOp      = 7'b0110011;  // R-type ALU and M extension
  localparam opcodeT opLui     = 7'b0110111;
  localparam opcodeT opBranch  = 7'b1100011;
  localparam opcodeT opJalr    = 7'b1100111;
  localparam opcodeT opJal     = 7'b1101111;

  //////////////////////////////
  // Select encodings
  //////////////////////////////
  localparam immSrcT immI = 3'd0;  // I-type, also loads and jalr
  localparam immSrcT immS = 3'd1;  // Stores
  localparam immSrcT immB = 3'd2;  // Branches
  localparam immSrcT immJ = 3'd3;  // jal
  localparam immSrcT immU = 3'd4;  // lui, auipc

  localparam resultSrcT resAlu = 3'd0;  // ALU or address result
  localparam resultSrcT resMem = 3'd1;  // Load data
  localparam resultSrcT resMdu = 3'd3;  // Multiply/divide unit

  localparam fwdSelT fwdNone = 2'b00;  // Register file value
  localparam fwdSelT fwdWb   = 2'b01;  // Writeback result
  localparam fwdSelT fwdMem  = 2'b10;  // Memory-stage ALU result

  //////////////////////////////
  // Main decoder control word
  //////////////////////////////
  // MSB to LSB:
  //   regWrite, immSrc[2:0], aluSrcA, aluSrcB, memRw[1:0], resultSrc[2:0],
  //   branch, aluOp, jump, aluResultSrc, mdu, illegal
  localparam int ctrlWidth = 17;
  typedef logic [ctrlWidth-1:0] ctrlWordT;

  localparam ctrlWordT ctrlIllegal = ctrlWordT'(1);  // Only the illegal bit set

endpackage

// ==== hdl/instrDecoder.sv ====
module instrDecoder #(
  parameter bit mSupported = 1'b1               // M extension legal
) (
  input  ctrlPkg::instrT     instrD,            // Instruction in Decode
  output ctrlPkg::regAdrT    rs1D, rs2D, rdD,   // Register fields
  output ctrlPkg::funct3T    funct3D,
  output ctrlPkg::funct7T    funct7D,
  output ctrlPkg::immSrcT    immSrcD,           // Immediate format
  output logic               aluSrcAD,          // 1 selects PC for operand A
  output logic               aluSrcBD,          // 1 selects immediate for operand B
  output logic               aluResultSrcD,     // 1 passes immediate straight through
  output logic               regWriteD,         // Writes rd
  output ctrlPkg::memRwT     memRwD,            // Memory read/write request
  output ctrlPkg::resultSrcT resultSrcD,        // Writeback source
  output logic               branchD, jumpD,
  output ctrlPkg::funct3T    aluSelectD,        // ALU operation
  output logic               subArithD,         // Inverted operand B or arithmetic shift
  output logic               mduD,              // Multiply/divide op
  output logic               illegalBaseInstrD  // Not a legal RV32I(M) encoding
);
  import ctrlPkg::*;

  opcodeT   opD;
  ctrlWordT ctrlD;          // Decoded control word
  logic     aluOpD;         // ALU op comes from funct3
  logic     funct7ZeroD;    // funct7 all zero
  logic     funct7b5D;      // funct7 = 0100000, sub/sra
  logic     iShiftD, iNoShiftD;
  logic     iFunctD, rFunctD, mFunctD;
  logic     lFunctD, sFunctD, bFunctD;
  logic     jrFunctD, fenceFunctD;
  logic     subD, sraD, sltD, sltuD;

  //////////////////////////////
  // Field extraction
  //////////////////////////////
  assign opD     = instrD[6:0];
  assign rdD     = instrD[11:7];
  assign funct3D = instrD[14:12];
  assign rs1D    = instrD[19:15];
  assign rs2D    = instrD[24:20];
  assign funct7D = instrD[31:25];

  //////////////////////////////
  // Legality checks
  //////////////////////////////
  assign funct7ZeroD = (funct7D == 7'b0000000);
  assign funct7b5D   = (funct7D == 7'b0100000);

  // Shift immediates carry funct7 in the upper bits of the immediate
  assign iShiftD   = ((funct3D == 3'b001) & funct7ZeroD) |
                     ((funct3D == 3'b101) & (funct7ZeroD | funct7b5D));  // slli, srli, srai
  assign iNoShiftD = (funct3D != 3'b001) & (funct3D != 3'b101);          // Any other I-type ALU
  assign iFunctD   = iShiftD | iNoShiftD;

  assign rFunctD = (((funct3D == 3'b000) | (funct3D == 3'b101)) & funct7b5D) |
                   funct7ZeroD;                                          // add..and, sub, sra
  assign mFunctD = (funct7D == 7'b0000001) & mSupported;                 // mul..remu

  assign lFunctD = (funct3D == 3'b000) | (funct3D == 3'b001) | (funct3D == 3'b010) |
                   (funct3D == 3'b100) | (funct3D == 3'b101);            // lb lh lw lbu lhu
  assign sFunctD = (funct3D == 3'b000) | (funct3D == 3'b001) |
                   (funct3D == 3'b010);                                  // sb sh sw
  assign bFunctD     = (funct3D[2:1] != 2'b01);                          // No 010 or 011 branch
  assign jrFunctD    = (funct3D == 3'b000);
  assign fenceFunctD = (funct3D == 3'b000);                              // fence only, no fence.i

  //////////////////////////////
  // Main decoder
  //////////////////////////////
  always_comb begin
    ctrlD = ctrlIllegal;                                                 // Fails a check below
    case (opD)
      opLoad:
        if (lFunctD) ctrlD = {1'b1, immI, 2'b01, 2'b10, resMem, 6'b0_0_0_0_0_0};
      opMiscMem:
        if (fenceFunctD) ctrlD = '0;                                     // Legal no-op
      opOpImm:
        if (iFunctD) ctrlD = {1'b1, immI, 2'b01, 2'b00, resAlu, 6'b0_1_0_0_0_0};
      opAuipc:
        ctrlD = {1'b1, immU, 2'b11, 2'b00, resAlu, 6'b0_0_0_0_0_0};      // PC + upper imm
      opStore:
        if (sFunctD) ctrlD = {1'b0, immS, 2'b01, 2'b01, resAlu, 6'b0_0_0_0_0_0};
      opOp:
        if (rFunctD) ctrlD = {1'b1, immI, 2'b00, 2'b00, resAlu, 6'b0_1_0_0_0_0};
        else if (mFunctD) ctrlD = {1'b1, immI, 2'b00, 2'b00, resMdu, 6'b0_0_0_0_1_0};
      opLui:
        ctrlD = {1'b1, immU, 2'b01, 2'b00, resAlu, 6'b0_0_0_1_0_0};      // Immediate bypasses ALU
      opBranch:
        if (bFunctD) ctrlD = {1'b0, immB, 2'b11, 2'b00, resAlu, 6'b1_0_0_0_0_0};
      opJalr:
        if (jrFunctD) ctrlD = {1'b1, immI, 2'b01, 2'b00, resAlu, 6'b0_0_1_1_0_0};
      opJal:
        ctrlD = {1'b1, immJ, 2'b11, 2'b00, resAlu, 6'b0_0_1_1_0_0};
      default:
        ctrlD = ctrlIllegal;                                             // Unknown opcode
    endcase
  end

  assign {regWriteD, immSrcD, aluSrcAD, aluSrcBD, memRwD, resultSrcD,
          branchD, aluOpD, jumpD, aluResultSrcD, mduD, illegalBaseInstrD} = ctrlD;

  //////////////////////////////
  // ALU operation
  //////////////////////////////
  assign subD  = (funct3D == 3'b000) & funct7D[5] & opD[5];  // opD[5] tells sub from addi
  assign sraD  = (funct3D == 3'b101) & funct7D[5];
  assign sltD  = (funct3D == 3'b010);
  assign sltuD = (funct3D == 3'b011);

  assign subArithD  = aluOpD & (subD | sraD | sltD | sltuD);
  assign aluSelectD = aluOpD ? funct3D : 3'b000;             // Add for address generation

endmodule

// ==== hdl/controlPipe.sv ====
module controlPipe (
  input  logic               clk,
  input  logic               rstN,
  input  logic               stallD, flushD,
  input  logic               stallE, flushE,
  input  logic               stallM, flushM,
  input  logic               stallW, flushW,
  // Decode-stage controls
  input  ctrlPkg::regAdrT    rs1D, rs2D, rdD,
  input  ctrlPkg::funct3T    funct3D,
  input  logic               aluSrcAD, aluSrcBD, aluResultSrcD,
  input  logic               regWriteD,
  input  ctrlPkg::memRwT     memRwD,
  input  ctrlPkg::resultSrcT resultSrcD,
  input  logic               branchD, jumpD,
  input  ctrlPkg::funct3T    aluSelectD,
  input  logic               subArithD, mduD,
  input  ctrlPkg::flagsT     flagsE,            // {eq, lt} from the comparator
  // Pipelined controls
  output logic               instrValidD, instrValidE, instrValidM,
  output ctrlPkg::regAdrT    rs1E, rs2E, rdE, rdM, rdW,
  output logic               aluSrcAE, aluSrcBE, aluResultSrcE,
  output ctrlPkg::funct3T    aluSelectE, funct3E, funct3M,
  output logic               subArithE, jumpE,
  output logic               branchSignedE,     // Signed compare for this branch
  output logic               pcSrcE,            // Redirect fetch
  output logic               intDivE,           // Divide or remainder
  output logic               mduActiveE,        // Mul/div occupies Execute
  output ctrlPkg::memRwT     memRwE, memRwM,
  output logic               regWriteM, regWriteW,
  output ctrlPkg::resultSrcT resultSrcW
);
  import ctrlPkg::*;

  localparam int eWidth = 3 * $bits(regAdrT) + 2 * $bits(funct3T) + $bits(memRwT) +
                          $bits(resultSrcT) + 9;
  localparam int mWidth = $bits(regAdrT) + $bits(funct3T) + $bits(memRwT) +
                          $bits(resultSrcT) + 2;
  localparam int wWidth = $bits(regAdrT) + $bits(resultSrcT) + 1;

  logic [eWidth-1:0] eNext, eReg;  // Execute register in/out
  logic [mWidth-1:0] mNext, mReg;  // Memory register in/out
  logic [wWidth-1:0] wNext, wReg;  // Writeback register in/out
  logic              regWriteE, branchE, mduE;
  resultSrcT         resultSrcE, resultSrcM;
  logic              eqE, ltE;
  logic              branchFlagE;  // eq or lt, picked by funct3
  logic              branchTakenE;

  //////////////////////////////
  // Decode valid
  //////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) instrValidD <= 1'b0;
    else if (flushD) instrValidD <= 1'b0;  // Bubble into Decode
    else if (!stallD) instrValidD <= 1'b1;
  end

  //////////////////////////////
  // Execute register
  //////////////////////////////
  assign eNext = {instrValidD, rs1D, rs2D, rdD, regWriteD, resultSrcD, memRwD, jumpD, branchD,
                  aluSrcAD, aluSrcBD, aluResultSrcD, aluSelectD, funct3D, subArithD, mduD};

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) eReg <= '0;
    else if (flushE) eReg <= '0;     // Flush beats stall
    else if (!stallE) eReg <= eNext;
  end

  assign {instrValidE, rs1E, rs2E, rdE, regWriteE, resultSrcE, memRwE, jumpE, branchE,
          aluSrcAE, aluSrcBE, aluResultSrcE, aluSelectE, funct3E, subArithE, mduE} = eReg;

  // Branch resolution
  assign {eqE, ltE}    = flagsE;
  assign branchFlagE   = funct3E[2] ? ltE : eqE;         // blt/bge/bltu/bgeu use lt
  assign branchTakenE  = branchFlagE ^ funct3E[0];       // bne, bge, bgeu invert
  assign pcSrcE        = jumpE | (branchE & branchTakenE);
  assign branchSignedE = branchE & (funct3E[2:1] != 2'b11);  // Not bltu/bgeu

  assign mduActiveE = (resultSrcE == resMdu);
  assign intDivE    = mduE & funct3E[2];                 // div, divu, rem, remu

  //////////////////////////////
  // Memory register
  //////////////////////////////
  assign mNext = {instrValidE, regWriteE, resultSrcE, memRwE, funct3E, rdE};

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) mReg <= '0;
    else if (flushM) mReg <= '0;
    else if (!stallM) mReg <= mNext;
  end

  assign {instrValidM, regWriteM, resultSrcM, memRwM, funct3M, rdM} = mReg;

  //////////////////////////////
  // Writeback register
  //////////////////////////////
  assign wNext = {regWriteM, resultSrcM, rdM};

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) wReg <= '0;
    else if (flushW) wReg <= '0;
    else if (!stallW) wReg <= wNext;
  end

  assign {regWriteW, resultSrcW, rdW} = wReg;

endmodule

// ==== hdl/hazardUnit.sv ====
module hazardUnit (
  input  ctrlPkg::regAdrT rs1D, rs2D,           // Decode sources
  input  ctrlPkg::regAdrT rs1E, rs2E, rdE,      // Execute sources and destination
  input  ctrlPkg::regAdrT rdM, rdW,
  input  ctrlPkg::memRwT  memRwD, memRwE,
  input  logic            mduActiveE,           // Mul/div in Execute
  input  logic            regWriteM, regWriteW,
  output ctrlPkg::fwdSelT forwardAE, forwardBE, // Operand bypass selects
  output logic            loadStallD,           // Load-use hazard
  output logic            storeStallD,          // Load right behind a store
  output logic            structuralStallD      // Any Decode stall
);
  import ctrlPkg::*;

  logic matchDE;     // Decode source needs the Execute result
  logic mduStallD;   // Mul/div result not ready for bypass

  // Memory result wins over Writeback, x0 is never bypassed
  function automatic fwdSelT fwdSel(input regAdrT rsE, input regAdrT rdMem, input logic wrMem,
                                    input regAdrT rdWb, input logic wrWb);
    fwdSelT sel;
    sel = fwdNone;
    if (rsE != '0) begin
      if ((rsE == rdMem) && wrMem) sel = fwdMem;
      else if ((rsE == rdWb) && wrWb) sel = fwdWb;
    end
    return sel;
  endfunction

  //////////////////////////////
  // Forwarding
  //////////////////////////////
  assign forwardAE = fwdSel(rs1E, rdM, regWriteM, rdW, regWriteW);
  assign forwardBE = fwdSel(rs2E, rdM, regWriteM, rdW, regWriteW);

  //////////////////////////////
  // Decode stalls
  //////////////////////////////
  assign matchDE = ((rs1D == rdE) | (rs2D == rdE)) & (rdE != '0);

  assign loadStallD  = memRwE[1] & matchDE;       // Load data only ready in Memory
  assign mduStallD   = mduActiveE & matchDE;      // Multi-cycle result
  assign storeStallD = memRwD[1] & memRwE[0];     // Read in Decode after write in Execute

  assign structuralStallD = loadStallD | storeStallD | mduStallD;

endmodule

// ==== hdl/controller.sv ====
module controller #(
  parameter bit mSupported = 1'b1                // M extension legal
) (
  input  logic               clk,
  input  logic               rstN,
  input  logic               stallD, flushD,
  input  logic               stallE, flushE,
  input  logic               stallM, flushM,
  input  logic               stallW, flushW,
  input  ctrlPkg::instrT     instrD,             // Instruction in Decode
  input  ctrlPkg::flagsT     flagsE,             // {eq, lt}
  // Decode stage
  output ctrlPkg::immSrcT    immSrcD,
  output logic               illegalBaseInstrD,
  output logic               jumpD, branchD,
  output ctrlPkg::regAdrT    rs1D, rs2D,
  output logic               loadStallD, storeStallD, structuralStallD,
  output logic               instrValidD,
  // Execute stage
  output logic               instrValidE,
  output ctrlPkg::regAdrT    rs2E, rdE,
  output logic               aluSrcAE, aluSrcBE, aluResultSrcE,
  output ctrlPkg::funct3T    aluSelectE, funct3E,
  output logic               subArithE, jumpE, branchSignedE, pcSrcE,
  output logic               intDivE, mduActiveE,
  output ctrlPkg::memRwT     memRwE,
  output ctrlPkg::fwdSelT    forwardAE, forwardBE,
  // Memory stage
  output logic               instrValidM,
  output ctrlPkg::regAdrT    rdM,
  output ctrlPkg::funct3T    funct3M,
  output ctrlPkg::memRwT     memRwM,
  // Writeback stage
  output logic               regWriteW,
  output ctrlPkg::resultSrcT resultSrcW,
  output ctrlPkg::regAdrT    rdW
);
  import ctrlPkg::*;

  regAdrT    rdD, rs1E;
  funct3T    funct3D, aluSelectD;
  logic      aluSrcAD, aluSrcBD, aluResultSrcD;
  logic      regWriteD, regWriteM;
  memRwT     memRwD;
  resultSrcT resultSrcD;
  logic      subArithD, mduD;

  //////////////////////////////
  // Decode
  //////////////////////////////
  instrDecoder #(.mSupported(mSupported)) decoder (
    .instrD, .rs1D, .rs2D, .rdD, .funct3D,
    .funct7D(),                                   // Consumed by the legality checks only
    .immSrcD, .aluSrcAD, .aluSrcBD, .aluResultSrcD, .regWriteD, .memRwD, .resultSrcD,
    .branchD, .jumpD, .aluSelectD, .subArithD, .mduD, .illegalBaseInstrD
  );

  //////////////////////////////
  // Pipeline registers
  //////////////////////////////
  controlPipe pipe (
    .clk, .rstN, .stallD, .flushD, .stallE, .flushE, .stallM, .flushM, .stallW, .flushW,
    .rs1D, .rs2D, .rdD, .funct3D, .aluSrcAD, .aluSrcBD, .aluResultSrcD, .regWriteD,
    .memRwD, .resultSrcD, .branchD, .jumpD, .aluSelectD, .subArithD, .mduD, .flagsE,
    .instrValidD, .instrValidE, .instrValidM, .rs1E, .rs2E, .rdE, .rdM, .rdW,
    .aluSrcAE, .aluSrcBE, .aluResultSrcE, .aluSelectE, .funct3E, .funct3M,
    .subArithE, .jumpE, .branchSignedE, .pcSrcE, .intDivE, .mduActiveE,
    .memRwE, .memRwM, .regWriteM, .regWriteW, .resultSrcW
  );

  //////////////////////////////
  // Hazards
  //////////////////////////////
  hazardUnit hazard (
    .rs1D, .rs2D, .rs1E, .rs2E, .rdE, .rdM, .rdW, .memRwD, .memRwE,
    .mduActiveE, .regWriteM, .regWriteW,
    .forwardAE, .forwardBE, .loadStallD, .storeStallD, .structuralStallD
  );

endmodule

// ==== tb/controllerTb.sv ====
module controllerTb;
  import ctrlPkg::*;

  localparam int maxVec    = 64;
  localparam int numFields = 18;   // Expected columns per vector
  localparam int numRandom = 200;  // Forwarding sequences

  // Instruction kinds in the random stream
  localparam logic [1:0] kindAdd   = 2'd0;
  localparam logic [1:0] kindStore = 2'd1;
  localparam logic [1:0] kindMul   = 2'd2;
  localparam logic [1:0] kindJal   = 2'd3;

  logic clk, rstN;
  logic stallD, flushD, stallE, flushE, stallM, flushM, stallW, flushW;
  instrT instrD;
  flagsT flagsE;
  immSrcT immSrcD;
  logic illegalBaseInstrD, jumpD, branchD;
  regAdrT rs1D, rs2D, rs2E, rdE, rdM, rdW;
  logic loadStallD, storeStallD, structuralStallD;
  logic instrValidD, instrValidE, instrValidM;
  logic aluSrcAE, aluSrcBE, aluResultSrcE;
  funct3T aluSelectE, funct3E, funct3M;
  logic subArithE, jumpE, branchSignedE, pcSrcE, intDivE, mduActiveE;
  memRwT memRwE, memRwM;
  fwdSelT forwardAE, forwardBE;
  logic regWriteW;
  resultSrcT resultSrcW;

  int          nVec, testNum [0:maxVec-1];
  logic [31:0] vInstr [0:maxVec-1], vFlags [0:maxVec-1], vCtl [0:maxVec-1];
  logic [31:0] vMask [0:maxVec-1], vExp [0:maxVec-1][0:numFields-1];
  logic [31:0] e [0:numFields-1], got [0:numFields-1];
  string       sigName [0:numFields-1];
  int          passCount, failCount, testErrs;
  bit          loaded;

  controller #(.mSupported(1'b1)) UUT (.*);

  always #4 clk = ~clk;  // Period 8

  //////////////////////////////
  // Helpers
  //////////////////////////////
  task automatic check(input string name, input logic [31:0] gotV, input logic [31:0] expV);
    if (gotV !== expV) begin
      $display("error %s expected %h got %h", name, expV, gotV);
      failCount++;
      testErrs++;
    end else passCount++;
  endtask

  task automatic reportTest(input int num);
    $display("test %0d %s (%0d errors)", num, (testErrs == 0) ? "passed" : "failed", testErrs);
    testErrs = 0;
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // Memory stage wins, then Writeback, and x0 always reads the register file
  function automatic fwdSelT refForward(input regAdrT rs, input regAdrT mRd, input bit mWr,
                                        input regAdrT wRd, input bit wWr);
    if (rs == 0) return 2'b00;
    if (mWr && rs == mRd) return 2'b10;
    if (wWr && rs == wRd) return 2'b01;
    return 2'b00;
  endfunction

  task automatic sampleOutputs();
    got[0]  = immSrcD;      got[1]  = jumpD;
    got[2]  = branchD;      got[3]  = illegalBaseInstrD;
    got[4]  = aluSelectE;   got[5]  = subArithE;
    got[6]  = memRwE;       got[7]  = intDivE;
    got[8]  = regWriteW;    got[9]  = rdW;
    got[10] = resultSrcW;   got[11] = pcSrcE;
    got[12] = branchSignedE;
    got[13] = loadStallD;   got[14] = storeStallD;
    got[15] = structuralStallD;
    got[16] = instrValidE;  got[17] = rdE;
  endtask

  task automatic loadVectors();
    int    fd, cnt, tn;
    string line;
    logic [31:0] ins, fl, ctl, msk;
    nVec = 0;
    fd = $fopen("tb/controllerStimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file");
      return;
    end
    while (!$feof(fd) && nVec < maxVec) begin
      void'($fgets(line, fd));
      cnt = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    tn, ins, fl, ctl, msk, e[0], e[1], e[2], e[3], e[4], e[5], e[6], e[7],
                    e[8], e[9], e[10], e[11], e[12], e[13], e[14], e[15], e[16], e[17]);
      if (cnt == 23) begin  // Comment lines scan nothing
        testNum[nVec] = tn;
        vInstr[nVec]  = ins;
        vFlags[nVec]  = fl;
        vCtl[nVec]    = ctl;
        vMask[nVec]   = msk;
        for (int f = 0; f < numFields; f++) vExp[nVec][f] = e[f];
        nVec++;
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////
  // Watchdog
  //////////////////////////////
  initial begin
    wait (loaded);
    #((nVec + numRandom + 20) * 8);
    $display("Timeout: the simulation did not finish in time");
    $display("Simulation FAILED");
    $finish;
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    logic [31:0] seed;
    regAdrT eRs1, eRs2, eRd, mRd, wRd, nRd, nRs1, nRs2;
    bit     eWr, mWr, wWr, nWr;
    logic [1:0] kind, eKind, mKind;
    int     curTest;
    clk = 1'b0;
    rstN = 1'b0;
    instrD = 32'h00000013;  // nop
    flagsE = '0;
    {stallD, flushD, stallE, flushE, stallM, flushM, stallW, flushW} = '0;
    sigName = '{"immSrcD", "jumpD", "branchD", "illegalBaseInstrD", "aluSelectE", "subArithE",
                "memRwE", "intDivE", "regWriteW", "rdW", "resultSrcW", "pcSrcE",
                "branchSignedE", "loadStallD", "storeStallD", "structuralStallD",
                "instrValidE", "rdE"};
    loadVectors();
    loaded = 1'b1;
    if (nVec == 0) begin
      $display("No stimulus vectors were loaded");
      failCount++;
    end

    repeat (5) @(negedge clk);
    rstN = 1'b1;
    // Test 1, everything cleared by reset
    check("instrValidD", instrValidD, 0);
    check("instrValidE", instrValidE, 0);
    check("instrValidM", instrValidM, 0);
    check("regWriteW", regWriteW, 0);
    check("memRwE", memRwE, 0);
    check("memRwM", memRwM, 0);
    check("jumpE", jumpE, 0);
    check("pcSrcE", pcSrcE, 0);
    check("mduActiveE", mduActiveE, 0);
    check("forwardAE", forwardAE, 0);
    check("forwardBE", forwardBE, 0);
    @(negedge clk);  // First edge with stallD low marks Decode valid
    check("instrValidD", instrValidD, 1);
    reportTest(1);

    // Directed vectors, drive on this falling edge and check before the next one
    curTest = (nVec > 0) ? testNum[0] : 0;
    for (int v = 0; v < nVec; v++) begin
      if (testNum[v] != curTest) begin
        reportTest(curTest);
        curTest = testNum[v];
      end
      instrD = vInstr[v];
      flagsE = vFlags[v][1:0];
      {stallD, flushD, stallE, flushE, stallM, flushM, stallW, flushW} = vCtl[v][7:0];
      @(negedge clk);
      sampleOutputs();
      for (int f = 0; f < numFields; f++)
        if (vMask[v][f]) check(sigName[f], got[f], vExp[v][f]);
    end
    if (nVec > 0) reportTest(curTest);
    {stallD, flushD, stallE, flushE, stallM, flushM, stallW, flushW} = '0;

    ////////////////////////////// Random forwarding
    seed = 32'd39551;
    {eRs1, eRs2, eRd, mRd, wRd} = '0;
    {eWr, mWr, wWr} = '0;
    {eKind, mKind} = '0;
    for (int i = 0; i < numRandom + 2; i++) begin
      seed = xorshift(seed);
      nRd  = {3'b0, seed[1:0]};  // Few registers so matches happen often
      nRs1 = {3'b0, seed[3:2]};
      nRs2 = {3'b0, seed[5:4]};
      kind = seed[7:6];
      nWr  = (kind != kindStore);
      // Model state after the coming edge
      wRd = mRd;
      wWr = mWr;
      mRd = eRd;
      mWr = eWr;
      mKind = eKind;
      eRs1 = nRs1;
      eRs2 = nRs2;
      eRd  = nWr ? nRd : 5'd0;  // Stores leave rd field zero
      eWr  = nWr;
      eKind = kind;
      case (kind)
        kindAdd:   instrD = {7'b0, nRs2, nRs1, 3'b000, nRd, 7'b0110011};
        kindStore: instrD = {7'b0, nRs2, nRs1, 3'b010, 5'b0, 7'b0100011};  // sw
        kindMul:   instrD = {7'b0000001, nRs2, nRs1, 3'b000, nRd, 7'b0110011};
        default:   instrD = {7'b0, nRs2, nRs1, 3'b000, nRd, 7'b1101111};  // jal
      endcase
      @(negedge clk);
      if (i >= 2) begin  // All three stages hold random entries
        check("forwardAE", forwardAE, refForward(eRs1, mRd, mWr, wRd, wWr));
        check("forwardBE", forwardBE, refForward(eRs2, mRd, mWr, wRd, wWr));
        check("rs1D", rs1D, nRs1);
        check("rs2D", rs2D, nRs2);
        check("instrValidD", instrValidD, 1);
        check("rs2E", rs2E, eRs2);
        check("funct3E", funct3E, (eKind == kindStore) ? 3'b010 : 3'b000);
        check("aluSrcAE", aluSrcAE, eKind == kindJal);  // PC is the jump base
        check("aluSrcBE", aluSrcBE, (eKind == kindStore) || (eKind == kindJal));
        check("aluResultSrcE", aluResultSrcE, eKind == kindJal);  // Link value skips the ALU
        check("jumpE", jumpE, eKind == kindJal);
        check("mduActiveE", mduActiveE, eKind == kindMul);
        check("instrValidM", instrValidM, 1);
        check("rdM", rdM, mRd);
        check("funct3M", funct3M, (mKind == kindStore) ? 3'b010 : 3'b000);
        check("memRwM", memRwM, (mKind == kindStore) ? 2'b01 : 2'b00);
      end
    end
    reportTest(5);

    $display("checks passed %0d failed %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== controller.f ====
hdl/ctrlPkg.sv
hdl/instrDecoder.sv
hdl/controlPipe.sv
hdl/hazardUnit.sv
hdl/controller.sv
tb/controllerTb.sv

// ==== tb/controllerStimulus.txt ====
# test instr flags ctl mask | imm jmp br ill alus sub mrw div rwW rdW rsW pcs bsg lst sst sst2 vE rdE
# ctl = {stallD flushD stallE flushE stallM flushM stallW flushW}, mask bit n checks column n
2 002081B3 0 00 100FF 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 0 1 03
2 40208233 0 00 100FF 0 0 0 0 0 1 0 0 0 00 0 0 0 0 0 0 1 04
2 00708293 0 00 100FF 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 0 1 05
2 0040A303 0 00 100FF 0 0 0 0 0 0 2 0 0 00 0 0 0 0 0 0 1 06
2 0020A423 0 00 100FF 1 0 0 0 0 0 1 0 0 00 0 0 0 0 0 0 1 08
2 00208463 0 00 100FF 2 0 1 0 0 0 0 0 0 00 0 0 0 0 0 0 1 08
2 010000EF 0 00 100FF 3 1 0 0 0 0 0 0 0 00 0 0 0 0 0 0 1 01
2 123453B7 0 00 100FF 4 0 0 0 0 0 0 0 0 00 0 0 0 0 0 0 1 07
2 02208433 0 00 100FF 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 0 1 08
2 0220C4B3 0 00 100FF 0 0 0 0 0 0 0 1 0 00 0 0 0 0 0 0 1 09
2 402091B3 0 00 100FF 0 0 0 1 0 0 0 0 0 00 0 0 0 0 0 0 1 03
3 00708293 0 00 20000 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 0 1 05
3 02208433 0 00 20000 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 0 1 08
3 00000013 0 00 00700 0 0 0 0 0 0 0 0 1 05 0 0 0 0 0 0 1 00
3 00000013 0 00 00700 0 0 0 0 0 0 0 0 1 08 3 0 0 0 0 0 1 00
3 123453B7 0 00 30000 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 0 1 07
3 002081B3 0 20 30000 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 0 1 07
3 002081B3 0 10 300F0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 0 0 00
4 00208463 2 00 01800 0 0 0 0 0 0 0 0 0 00 0 1 1 0 0 0 0 00
4 00208463 0 00 01800 0 0 0 0 0 0 0 0 0 00 0 0 1 0 0 0 0 00
4 00209463 2 00 01800 0 0 0 0 0 0 0 0 0 00 0 0 1 0 0 0 0 00
4 00209463 0 00 01800 0 0 0 0 0 0 0 0 0 00 0 1 1 0 0 0 0 00
4 0020C463 1 00 01800 0 0 0 0 0 0 0 0 0 00 0 1 1 0 0 0 0 00
4 0020C463 2 00 01800 0 0 0 0 0 0 0 0 0 00 0 0 1 0 0 0 0 00
4 0020D463 1 00 01800 0 0 0 0 0 0 0 0 0 00 0 0 1 0 0 0 0 00
4 0020D463 0 00 01800 0 0 0 0 0 0 0 0 0 00 0 1 1 0 0 0 0 00
4 0020E463 1 00 01800 0 0 0 0 0 0 0 0 0 00 0 1 0 0 0 0 0 00
4 0020E463 2 00 01800 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 0 0 00
4 0020F463 0 00 01800 0 0 0 0 0 0 0 0 0 00 0 1 0 0 0 0 0 00
4 0020F463 1 00 01800 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 0 0 00
4 002081B3 3 00 01800 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 0 0 00
4 010000EF 0 00 01800 0 0 0 0 0 0 0 0 0 00 0 1 0 0 0 0 0 00
6 0040A303 0 00 00000 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 0 0 00
6 002301B3 0 20 0E000 0 0 0 0 0 0 0 0 0 00 0 0 0 1 0 1 0 00
6 02208433 0 00 00000 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 0 0 00
6 002401B3 0 20 0E000 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 1 0 00
6 0020A423 0 00 00000 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 0 0 00
6 0040A303 0 20 0E000 0 0 0 0 0 0 0 0 0 00 0 0 0 0 1 1 0 00
6 00000013 0 00 0E000 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 0 0 00
6 00000013 0 00 0E000 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 0 0 00
